// File: design/rv_alu_pkg.sv
`default_nettype none

package rv_alu_pkg;

    //////////////////////////////////////////////////
    // Widths

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    //////////////////////////////////////////////////
    // Major opcodes accepted by the decoder

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct3 codes, shared by register and immediate forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7, alternate form selects SUB and SRA
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    //////////////////////////////////////////////////
    // Internal ALU operation codes

    localparam int ALU_OP_W = 4;

    localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SLL    = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SLT    = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU   = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_XOR    = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SRL    = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRA    = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_OR     = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'd9;
    localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'd10;

    //////////////////////////////////////////////////
    // Instruction word layouts

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0]           imm;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    // One 32-bit word, three views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        u_fmt_t u;
    } instr_t;

endpackage

`default_nettype wire

// File: design/instr_decode.sv
`timescale 1ns/100ps
`default_nettype none

module instr_decode (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 instr_valid,
    input  rv_alu_pkg::instr_t                   instr,
    output logic                                 dec_valid,
    output logic [rv_alu_pkg::ALU_OP_W-1:0]      dec_alu_op,
    output logic [rv_alu_pkg::REG_ADDR_W-1:0]    dec_rs1,
    output logic [rv_alu_pkg::REG_ADDR_W-1:0]    dec_rs2,
    output logic [rv_alu_pkg::REG_ADDR_W-1:0]    dec_rd,
    output logic                                 dec_wr_en,
    output logic                                 dec_use_imm,
    output logic [rv_alu_pkg::XLEN-1:0]          dec_imm,
    output logic                                 illegal_instr
);

    logic                                 legal;
    logic [rv_alu_pkg::ALU_OP_W-1:0]      alu_op;
    logic                                 use_imm;
    logic [rv_alu_pkg::XLEN-1:0]          imm;
    logic [rv_alu_pkg::REG_ADDR_W-1:0]    rs1;
    logic                                 r_f7_base;
    logic                                 r_f7_alt;
    logic                                 i_f7_base;
    logic                                 i_f7_alt;

    // funct7 checks, R view and upper immediate bits of the shift immediates
    assign r_f7_base = (instr.r.funct7 == rv_alu_pkg::F7_BASE);
    assign r_f7_alt  = (instr.r.funct7 == rv_alu_pkg::F7_ALT);
    assign i_f7_base = (instr.i.imm[11:5] == rv_alu_pkg::F7_BASE);
    assign i_f7_alt  = (instr.i.imm[11:5] == rv_alu_pkg::F7_ALT);

    //////////////////////////////////////////////////
    // Combinational decode

    always_comb begin
        legal   = 1'b0;
        alu_op  = rv_alu_pkg::ALU_ADD;
        use_imm = 1'b0;
        imm     = {{(rv_alu_pkg::XLEN-12){instr.i.imm[11]}}, instr.i.imm};
        rs1     = instr.r.rs1;

        case (instr.r.opcode)
            rv_alu_pkg::OPC_OP: begin
                legal = r_f7_base;
                case (instr.r.funct3)
                    rv_alu_pkg::F3_ADD_SUB: begin
                        alu_op = r_f7_alt ? rv_alu_pkg::ALU_SUB : rv_alu_pkg::ALU_ADD;
                        legal  = r_f7_base | r_f7_alt;
                    end
                    rv_alu_pkg::F3_SRL_SRA: begin
                        alu_op = r_f7_alt ? rv_alu_pkg::ALU_SRA : rv_alu_pkg::ALU_SRL;
                        legal  = r_f7_base | r_f7_alt;
                    end
                    rv_alu_pkg::F3_SLL:  alu_op = rv_alu_pkg::ALU_SLL;
                    rv_alu_pkg::F3_SLT:  alu_op = rv_alu_pkg::ALU_SLT;
                    rv_alu_pkg::F3_SLTU: alu_op = rv_alu_pkg::ALU_SLTU;
                    rv_alu_pkg::F3_XOR:  alu_op = rv_alu_pkg::ALU_XOR;
                    rv_alu_pkg::F3_OR:   alu_op = rv_alu_pkg::ALU_OR;
                    default:             alu_op = rv_alu_pkg::ALU_AND;
                endcase
            end
            rv_alu_pkg::OPC_OP_IMM: begin
                legal   = 1'b1;
                use_imm = 1'b1;
                case (instr.i.funct3)
                    rv_alu_pkg::F3_ADD_SUB: alu_op = rv_alu_pkg::ALU_ADD;
                    rv_alu_pkg::F3_SLL: begin
                        alu_op = rv_alu_pkg::ALU_SLL;
                        legal  = i_f7_base;
                    end
                    rv_alu_pkg::F3_SRL_SRA: begin
                        alu_op = i_f7_alt ? rv_alu_pkg::ALU_SRA : rv_alu_pkg::ALU_SRL;
                        legal  = i_f7_base | i_f7_alt;
                    end
                    rv_alu_pkg::F3_SLT:  alu_op = rv_alu_pkg::ALU_SLT;
                    rv_alu_pkg::F3_SLTU: alu_op = rv_alu_pkg::ALU_SLTU;
                    rv_alu_pkg::F3_XOR:  alu_op = rv_alu_pkg::ALU_XOR;
                    rv_alu_pkg::F3_OR:   alu_op = rv_alu_pkg::ALU_OR;
                    default:             alu_op = rv_alu_pkg::ALU_AND;
                endcase
            end
            rv_alu_pkg::OPC_LUI: begin
                legal   = 1'b1;
                use_imm = 1'b1;
                alu_op  = rv_alu_pkg::ALU_PASS_B;
                imm     = {instr.u.imm, 12'b0};
                // No source register for LUI
                rs1     = '0;
            end
            default: legal = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // Decode register

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid     <= 1'b0;
            dec_wr_en     <= 1'b0;
            illegal_instr <= 1'b0;
        end else begin
            dec_valid     <= instr_valid & legal;
            dec_wr_en     <= instr_valid & legal & (instr.r.rd != '0);
            illegal_instr <= instr_valid & ~legal;
        end
    end

    // rd sits in the same bits in every layout
    always_ff @(posedge clk) begin
        dec_alu_op  <= alu_op;
        dec_rs1     <= rs1;
        dec_rs2     <= instr.r.rs2;
        dec_rd      <= instr.r.rd;
        dec_use_imm <= use_imm;
        dec_imm     <= imm;
    end

endmodule

`default_nettype wire

// File: design/alu_execute.sv
`timescale 1ns/100ps
`default_nettype none

module alu_execute (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 dec_valid,
    input  logic [rv_alu_pkg::ALU_OP_W-1:0]      dec_alu_op,
    input  logic [rv_alu_pkg::REG_ADDR_W-1:0]    dec_rs1,
    input  logic [rv_alu_pkg::REG_ADDR_W-1:0]    dec_rs2,
    input  logic [rv_alu_pkg::REG_ADDR_W-1:0]    dec_rd,
    input  logic                                 dec_wr_en,
    input  logic                                 dec_use_imm,
    input  logic [rv_alu_pkg::XLEN-1:0]          dec_imm,
    input  logic [rv_alu_pkg::XLEN-1:0]          rs1_data,
    input  logic [rv_alu_pkg::XLEN-1:0]          rs2_data,
    output logic                                 ex_wr_en,
    output logic [rv_alu_pkg::REG_ADDR_W-1:0]    ex_rd,
    output logic [rv_alu_pkg::XLEN-1:0]          ex_result
);

    logic                              fwd_a;
    logic                              fwd_b;
    logic [rv_alu_pkg::XLEN-1:0]       op_a;
    logic [rv_alu_pkg::XLEN-1:0]       rs2_val;
    logic [rv_alu_pkg::XLEN-1:0]       op_b;
    logic [4:0]                        shamt;
    logic                              lt_signed;
    logic                              lt_unsigned;
    logic [rv_alu_pkg::XLEN-1:0]       alu_out;

    //////////////////////////////////////////////////
    // Operand selection

    // Previous instruction is still in the result register
    // ex_wr_en is never set for x0, so no index check is needed here
    assign fwd_a = ex_wr_en & (ex_rd == dec_rs1);
    assign fwd_b = ex_wr_en & (ex_rd == dec_rs2);

    assign op_a    = fwd_a ? ex_result : rs1_data;
    assign rs2_val = fwd_b ? ex_result : rs2_data;
    assign op_b    = dec_use_imm ? dec_imm : rs2_val;

    //////////////////////////////////////////////////
    // ALU

    assign shamt       = op_b[4:0];
    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    always_comb begin
        case (dec_alu_op)
            rv_alu_pkg::ALU_ADD:    alu_out = op_a + op_b;
            rv_alu_pkg::ALU_SUB:    alu_out = op_a - op_b;
            rv_alu_pkg::ALU_SLL:    alu_out = op_a << shamt;
            rv_alu_pkg::ALU_SLT:    alu_out = {{(rv_alu_pkg::XLEN-1){1'b0}}, lt_signed};
            rv_alu_pkg::ALU_SLTU:   alu_out = {{(rv_alu_pkg::XLEN-1){1'b0}}, lt_unsigned};
            rv_alu_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
            rv_alu_pkg::ALU_SRL:    alu_out = op_a >> shamt;
            rv_alu_pkg::ALU_SRA:    alu_out = $unsigned($signed(op_a) >>> shamt);
            rv_alu_pkg::ALU_OR:     alu_out = op_a | op_b;
            rv_alu_pkg::ALU_AND:    alu_out = op_a & op_b;
            rv_alu_pkg::ALU_PASS_B: alu_out = op_b;
            default:                alu_out = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Result register

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_wr_en <= 1'b0;
        end else begin
            ex_wr_en <= dec_valid & dec_wr_en;
        end
    end

    always_ff @(posedge clk) begin
        ex_rd     <= dec_rd;
        ex_result <= alu_out;
    end

endmodule

`default_nettype wire

// File: design/reg_writeback.sv
`timescale 1ns/100ps
`default_nettype none

module reg_writeback (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [rv_alu_pkg::REG_ADDR_W-1:0]    dec_rs1,
    input  logic [rv_alu_pkg::REG_ADDR_W-1:0]    dec_rs2,
    input  logic                                 ex_wr_en,
    input  logic [rv_alu_pkg::REG_ADDR_W-1:0]    ex_rd,
    input  logic [rv_alu_pkg::XLEN-1:0]          ex_result,
    output logic [rv_alu_pkg::XLEN-1:0]          rs1_data,
    output logic [rv_alu_pkg::XLEN-1:0]          rs2_data,
    output logic                                 wb_valid,
    output logic [rv_alu_pkg::REG_ADDR_W-1:0]    wb_rd,
    output logic [rv_alu_pkg::XLEN-1:0]          wb_data
);

    logic [rv_alu_pkg::XLEN-1:0] regs [rv_alu_pkg::NUM_REGS];

    //////////////////////////////////////////////////
    // Register file

    // x0 is cleared here and never written afterwards
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rv_alu_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (ex_wr_en) begin
            regs[ex_rd] <= ex_result;
        end
    end

    // Read ports, combinational
    assign rs1_data = regs[dec_rs1];
    assign rs2_data = regs[dec_rs2];

    //////////////////////////////////////////////////
    // Writeback outputs

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_wr_en;
        end
    end

    // Same write as the register file, one copy per update
    always_ff @(posedge clk) begin
        wb_rd   <= ex_rd;
        wb_data <= ex_result;
    end

endmodule

`default_nettype wire

// File: design/rv_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_top (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 instr_valid,
    input  rv_alu_pkg::instr_t                   instr,
    output logic                                 wb_valid,
    output logic [rv_alu_pkg::REG_ADDR_W-1:0]    wb_rd,
    output logic [rv_alu_pkg::XLEN-1:0]          wb_data,
    output logic                                 illegal_instr
);

    // Decode to execute
    logic                                 dec_valid;
    logic [rv_alu_pkg::ALU_OP_W-1:0]      dec_alu_op;
    logic [rv_alu_pkg::REG_ADDR_W-1:0]    dec_rs1;
    logic [rv_alu_pkg::REG_ADDR_W-1:0]    dec_rs2;
    logic [rv_alu_pkg::REG_ADDR_W-1:0]    dec_rd;
    logic                                 dec_wr_en;
    logic                                 dec_use_imm;
    logic [rv_alu_pkg::XLEN-1:0]          dec_imm;

    // Register file reads
    logic [rv_alu_pkg::XLEN-1:0]          rs1_data;
    logic [rv_alu_pkg::XLEN-1:0]          rs2_data;

    // Execute to writeback
    logic                                 ex_wr_en;
    logic [rv_alu_pkg::REG_ADDR_W-1:0]    ex_rd;
    logic [rv_alu_pkg::XLEN-1:0]          ex_result;

    //////////////////////////////////////////////////
    // Decode

    instr_decode i_decode (
        .clk           (clk),
        .rst           (rst),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .dec_valid     (dec_valid),
        .dec_alu_op    (dec_alu_op),
        .dec_rs1       (dec_rs1),
        .dec_rs2       (dec_rs2),
        .dec_rd        (dec_rd),
        .dec_wr_en     (dec_wr_en),
        .dec_use_imm   (dec_use_imm),
        .dec_imm       (dec_imm),
        .illegal_instr (illegal_instr)
    );

    //////////////////////////////////////////////////
    // Execute

    alu_execute i_execute (
        .clk         (clk),
        .rst         (rst),
        .dec_valid   (dec_valid),
        .dec_alu_op  (dec_alu_op),
        .dec_rs1     (dec_rs1),
        .dec_rs2     (dec_rs2),
        .dec_rd      (dec_rd),
        .dec_wr_en   (dec_wr_en),
        .dec_use_imm (dec_use_imm),
        .dec_imm     (dec_imm),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .ex_wr_en    (ex_wr_en),
        .ex_rd       (ex_rd),
        .ex_result   (ex_result)
    );

    //////////////////////////////////////////////////
    // Register file and writeback

    reg_writeback i_writeback (
        .clk       (clk),
        .rst       (rst),
        .dec_rs1   (dec_rs1),
        .dec_rs2   (dec_rs2),
        .ex_wr_en  (ex_wr_en),
        .ex_rd     (ex_rd),
        .ex_result (ex_result),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

endmodule

`default_nettype wire

// File: tests/tb_rv_core_chk.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core_chk (
    input logic       clk,
    input logic       rst,
    input logic       instr_valid,
    input logic       wb_valid,
    input logic [4:0] wb_rd,
    input logic       illegal_instr
);

    int assert_fails = 0;

    //////////////////////////////////////////////////
    // Outputs are cleared by the first edge in reset

    a_quiet_in_reset: assert property (@(posedge clk)
        (rst && $past(rst)) |-> (!wb_valid && !illegal_instr))
        else begin
            assert_fails++;
            $error("wb_valid or illegal_instr high during reset");
        end

    // x0 is never reported as written
    a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> (wb_rd != 5'd0))
        else begin
            assert_fails++;
            $error("writeback reported for x0");
        end

    // Two pulses in a row need two strobes in a row, one and two edges back
    a_illegal_single: assert property (@(posedge clk) disable iff (rst)
        (illegal_instr && $past(illegal_instr)) |->
            ($past(instr_valid) && $past(instr_valid, 2)))
        else begin
            assert_fails++;
            $error("illegal_instr high for two cycles without two instructions");
        end

endmodule

bind rv_core_top tb_rv_core_chk i_chk (
    .clk           (clk),
    .rst           (rst),
    .instr_valid   (instr_valid),
    .wb_valid      (wb_valid),
    .wb_rd         (wb_rd),
    .illegal_instr (illegal_instr)
);

`default_nettype wire

// File: tests/tb_rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;

    // Roughly 300 instructions with their gaps, plus margin
    localparam int MAX_CYCLES = 3000;

    logic               clk;
    logic               rst;
    logic               instr_valid;
    rv_alu_pkg::instr_t instr;
    logic               wb_valid;
    logic [4:0]         wb_rd;
    logic [31:0]        wb_data;
    logic               illegal_instr;

    // Reference register model and expected DUT events
    logic [31:0] ref_regs [32];
    logic [4:0]  exp_rd_q [$];
    logic [31:0] exp_data_q [$];
    int          exp_cycle_q [$];
    int          ill_cycle_q [$];

    int          cycle;
    int          value_errors;
    int          other_errors;
    logic [31:0] lcg_state;
    string       current_test;

    rv_core_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .illegal_instr (illegal_instr)
    );

    always #20 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    //////////////////////////////////////////////////
    // Helpers

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        // High bits are the better ones, moved down
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    function automatic rv_alu_pkg::instr_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                                 input logic [4:0] rd, input logic [4:0] rs1,
                                                 input logic [4:0] rs2);
        rv_alu_pkg::instr_t w;
        w.r = {f7, rs2, rs1, f3, rd, rv_alu_pkg::OPC_OP};
        return w;
    endfunction

    function automatic rv_alu_pkg::instr_t enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                                 input logic [4:0] rd, input logic [4:0] rs1);
        rv_alu_pkg::instr_t w;
        w.i = {imm, rs1, f3, rd, rv_alu_pkg::OPC_OP_IMM};
        return w;
    endfunction

    function automatic rv_alu_pkg::instr_t enc_u(input logic [19:0] imm, input logic [4:0] rd);
        rv_alu_pkg::instr_t w;
        w.u = {imm, rd, rv_alu_pkg::OPC_LUI};
        return w;
    endfunction

    // RV32I arithmetic, alt selects SUB and SRA
    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5: begin
                if (alt) return (a >> b[4:0]) | (a[31] ? ~(32'hffffffff >> b[4:0]) : 32'd0);
                else return a >> b[4:0];
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Drive one instruction and record what the model expects of it
    task automatic issue(input rv_alu_pkg::instr_t w);
        logic        legal;
        logic        alt;
        logic [31:0] val;
        logic [31:0] imm;
        @(posedge clk);
        #2;
        instr_valid = 1'b1;
        instr       = w;
        legal = 1'b1;
        alt   = 1'b0;
        val   = '0;
        imm   = {{20{w.i.imm[11]}}, w.i.imm};
        case (w.r.opcode)
            rv_alu_pkg::OPC_OP: begin
                alt   = (w.r.funct7 == rv_alu_pkg::F7_ALT);
                legal = (w.r.funct7 == rv_alu_pkg::F7_BASE) ||
                        (alt && (w.r.funct3 == rv_alu_pkg::F3_ADD_SUB ||
                                 w.r.funct3 == rv_alu_pkg::F3_SRL_SRA));
                val   = ref_alu(w.r.funct3, alt, ref_regs[w.r.rs1], ref_regs[w.r.rs2]);
            end
            rv_alu_pkg::OPC_OP_IMM: begin
                if (w.i.funct3 == rv_alu_pkg::F3_SLL)
                    legal = (w.i.imm[11:5] == rv_alu_pkg::F7_BASE);
                if (w.i.funct3 == rv_alu_pkg::F3_SRL_SRA) begin
                    alt   = (w.i.imm[11:5] == rv_alu_pkg::F7_ALT);
                    legal = alt || (w.i.imm[11:5] == rv_alu_pkg::F7_BASE);
                end
                val = ref_alu(w.i.funct3, alt, ref_regs[w.i.rs1], imm);
            end
            rv_alu_pkg::OPC_LUI: val = {w.u.imm, 12'h000};
            default:             legal = 1'b0;
        endcase
        if (!legal) begin
            ill_cycle_q.push_back(cycle + 1);
        end else if (w.r.rd != 5'd0) begin
            ref_regs[w.r.rd] = val;
            exp_rd_q.push_back(w.r.rd);
            exp_data_q.push_back(val);
            exp_cycle_q.push_back(cycle + 3);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            instr_valid = 1'b0;
            instr       = '0;
        end
    endtask

    task automatic drain();
        idle(1);
        while (exp_rd_q.size() != 0 || ill_cycle_q.size() != 0) @(negedge clk);
        // A few more cycles to catch stray writebacks
        repeat (3) @(negedge clk);
    endtask

    task automatic load_random(input logic [4:0] rd);
        logic [31:0] v;
        v = lcg_next();
        issue(enc_u(v[31:12], rd));
        issue(enc_i(v[11:0], rv_alu_pkg::F3_ADD_SUB, rd, rd));
        idle(1);
    endtask

    //////////////////////////////////////////////////
    // Monitor

    always @(negedge clk) begin
        if (!rst) begin
            if (wb_valid === 1'b1) begin
                if (exp_rd_q.size() == 0) begin
                    $display("[%s] Writeback to x%0d arrived when none was expected",
                             current_test, wb_rd);
                    other_errors++;
                end else begin
                    if (wb_rd !== exp_rd_q[0]) begin
                        $display("** Error [%s] wb_rd: expected x%0d, actual x%0d",
                                 current_test, exp_rd_q[0], wb_rd);
                        value_errors++;
                    end
                    if (wb_data !== exp_data_q[0]) begin
                        $display("** Error [%s] wb_data x%0d: expected %h, actual %h",
                                 current_test, exp_rd_q[0], exp_data_q[0], wb_data);
                        value_errors++;
                    end
                    if (cycle != exp_cycle_q[0]) begin
                        $display("** Error [%s] writeback cycle: expected %0d, actual %0d",
                                 current_test, exp_cycle_q[0], cycle);
                        value_errors++;
                    end
                    void'(exp_rd_q.pop_front());
                    void'(exp_data_q.pop_front());
                    void'(exp_cycle_q.pop_front());
                end
            end else if (exp_cycle_q.size() != 0 && exp_cycle_q[0] < cycle) begin
                $display("[%s] Expected writeback to x%0d never arrived",
                         current_test, exp_rd_q[0]);
                other_errors++;
                void'(exp_rd_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(exp_cycle_q.pop_front());
            end
            if (illegal_instr === 1'b1) begin
                if (ill_cycle_q.size() != 0 && ill_cycle_q[0] == cycle) begin
                    void'(ill_cycle_q.pop_front());
                end else begin
                    $display("[%s] Unexpected illegal_instr pulse at cycle %0d",
                             current_test, cycle);
                    other_errors++;
                end
            end else if (ill_cycle_q.size() != 0 && ill_cycle_q[0] <= cycle) begin
                $display("[%s] Illegal instruction was not flagged", current_test);
                other_errors++;
                void'(ill_cycle_q.pop_front());
            end
        end
    end

    //////////////////////////////////////////////////
    // Directed tests

    task automatic test_reset_idle();
        current_test = "reset_idle";
        repeat (10) begin
            @(negedge clk);
            if (wb_valid !== 1'b0 || illegal_instr !== 1'b0) begin
                $display("[%s] Output active with no instruction presented", current_test);
                other_errors++;
            end
        end
    endtask

    task automatic test_reg_reg();
        logic [31:0] v;
        current_test = "reg_reg";
        for (int k = 1; k < 4; k++) begin
            load_random(5'(k));
        end
        v = lcg_next();
        // x4 negative, for SRA and the signed compares
        issue(enc_u({1'b1, v[18:0]}, 5'd4));
        idle(2);
        for (int k = 0; k < 8; k++) begin
            for (int alt = 0; alt < 2; alt++) begin
                if (alt == 0 || k == 0 || k == 5) begin
                    v[6:0] = (alt != 0) ? rv_alu_pkg::F7_ALT : rv_alu_pkg::F7_BASE;
                    issue(enc_r(v[6:0], 3'(k), 5'(5 + k), 5'd1, 5'd2));
                    idle(2);
                    issue(enc_r(v[6:0], 3'(k), 5'(5 + k), 5'd4, 5'd3));
                    idle(2);
                    issue(enc_r(v[6:0], 3'(k), 5'(5 + k), 5'd3, 5'd4));
                    idle(2);
                end
            end
        end
        drain();
    endtask

    task automatic test_imm();
        logic [31:0] r;
        logic [11:0] imm;
        current_test = "imm";
        for (int k = 0; k < 8; k++) begin
            for (int j = 0; j < 2; j++) begin
                r   = lcg_next();
                imm = r[11:0];
                // Shift immediates carry funct7 in the upper bits
                if (k == 1 || k == 5)
                    imm[11:5] = (k == 5 && j == 1) ? rv_alu_pkg::F7_ALT : rv_alu_pkg::F7_BASE;
                issue(enc_i(imm, 3'(k), 5'(15 + k), 5'(1 + (k + j) % 4)));
                idle(1);
            end
        end
        drain();
    endtask

    task automatic test_x0_lui();
        logic [31:0] v;
        current_test = "x0_lui";
        v = lcg_next();
        issue(enc_i(12'h123, rv_alu_pkg::F3_ADD_SUB, 5'd0, 5'd1));
        idle(2);
        issue(enc_r(rv_alu_pkg::F7_BASE, rv_alu_pkg::F3_OR, 5'd0, 5'd1, 5'd2));
        // Right after a write to x0, x0 must still read 0
        issue(enc_r(rv_alu_pkg::F7_BASE, rv_alu_pkg::F3_ADD_SUB, 5'd20, 5'd0, 5'd0));
        issue(enc_i(12'hfff, rv_alu_pkg::F3_ADD_SUB, 5'd21, 5'd0));
        idle(2);
        issue(enc_u(v[31:12], 5'd22));
        idle(2);
        issue(enc_u(20'hfffff, 5'd23));
        issue(enc_i(12'h000, rv_alu_pkg::F3_OR, 5'd24, 5'd23));
        drain();
    endtask

    task automatic test_chain();
        logic [31:0] r;
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  rd;
        logic [4:0]  prev;
        logic [4:0]  back2;
        logic [11:0] imm;
        current_test = "chain";
        for (int k = 0; k < 4; k++) begin
            load_random(5'(10 + k));
        end
        // One instruction per cycle, sources one and two back
        for (int k = 0; k < 60; k++) begin
            r     = lcg_next();
            f3    = r[3:1];
            alt   = r[4] && (f3 == rv_alu_pkg::F3_ADD_SUB || f3 == rv_alu_pkg::F3_SRL_SRA);
            rd    = 5'(10 + k % 4);
            prev  = 5'(10 + (k + 3) % 4);
            back2 = 5'(10 + (k + 2) % 4);
            imm   = r[27:16];
            if (f3 == rv_alu_pkg::F3_SLL || f3 == rv_alu_pkg::F3_SRL_SRA)
                imm[11:5] = alt ? rv_alu_pkg::F7_ALT : rv_alu_pkg::F7_BASE;
            if (r[5])
                issue(enc_i(imm, f3, rd, r[6] ? back2 : prev));
            else if (r[6])
                issue(enc_r(alt ? rv_alu_pkg::F7_ALT : rv_alu_pkg::F7_BASE, f3, rd, back2, prev));
            else
                issue(enc_r(alt ? rv_alu_pkg::F7_ALT : rv_alu_pkg::F7_BASE, f3, rd, prev, back2));
        end
        drain();
    endtask

    task automatic test_illegal();
        rv_alu_pkg::instr_t bad_opc;
        current_test = "illegal";
        bad_opc = enc_i(12'h7ff, rv_alu_pkg::F3_ADD_SUB, 5'd27, 5'd1);
        // LOAD opcode, not supported here
        bad_opc.i.opcode = 7'b0000011;
        issue(enc_i(12'h055, rv_alu_pkg::F3_ADD_SUB, 5'd27, 5'd1));
        issue(bad_opc);
        issue(enc_r(rv_alu_pkg::F7_BASE, rv_alu_pkg::F3_ADD_SUB, 5'd28, 5'd27, 5'd2));
        idle(2);
        // Two illegal encodings back to back
        issue(bad_opc);
        issue(enc_r(7'b0000001, rv_alu_pkg::F3_ADD_SUB, 5'd29, 5'd1, 5'd2));
        idle(1);
        issue(enc_r(rv_alu_pkg::F7_ALT, rv_alu_pkg::F3_XOR, 5'd29, 5'd1, 5'd2));
        idle(1);
        issue(enc_i({rv_alu_pkg::F7_ALT, 5'd3}, rv_alu_pkg::F3_SLL, 5'd29, 5'd1));
        idle(1);
        issue(enc_i({7'h01, 5'd3}, rv_alu_pkg::F3_SRL_SRA, 5'd29, 5'd1));
        issue(enc_r(rv_alu_pkg::F7_BASE, rv_alu_pkg::F3_OR, 5'd30, 5'd29, 5'd1));
        drain();
    endtask

    //////////////////////////////////////////////////
    // Summary, timeout and main sequence

    task automatic report_and_finish(input bit timed_out);
        $display("Summary: %0d value errors, %0d other errors, %0d assertion failures",
                 value_errors, other_errors, i_dut.i_chk.assert_fails);
        if (!timed_out && value_errors == 0 && other_errors == 0 &&
            i_dut.i_chk.assert_fails == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    always @(negedge clk) begin
        if (cycle >= MAX_CYCLES) begin
            $display("Run stopped at cycle %0d, the tests did not finish", cycle);
            report_and_finish(1'b1);
        end
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        cycle        = 0;
        value_errors = 0;
        other_errors = 0;
        lcg_state    = 32'd42;
        current_test = "reset";
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        test_reset_idle();
        test_reg_reg();
        test_imm();
        test_x0_lui();
        test_chain();
        test_illegal();
        report_and_finish(1'b0);
    end

endmodule

`default_nettype wire

// File: vlog.f
design/rv_alu_pkg.sv
design/instr_decode.sv
design/alu_execute.sv
design/reg_writeback.sv
design/rv_core_top.sv
tests/tb_rv_core_chk.sv
tests/tb_rv_core.sv
